// File: all.f
verilog/gemv_pkg.sv
verilog/mac_lane.sv
verilog/tile_bridge.sv
verilog/gemv_sequencer.sv
verilog/result_packer.sv
verilog/gemv_engine.sv
test/buffer_model.sv
test/tb_gemv_engine.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_gemv_engine -Mdir obj_dir -o sim_gemv
	./obj_dir/sim_gemv | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_gemv_engine.sv
`timescale 1ns/1ns

module tb_gemv_engine;
    import gemv_pkg::*;

    localparam int MAX_ROWS = 40;
    localparam int MAX_COLS = 96;
    localparam int N_TESTS  = 5;

    // Command list, rows and cols per command
    localparam int T_ROWS [N_TESTS] = '{12, 13, 40, 20, 7};
    localparam int T_COLS [N_TESTS] = '{96, 50, 77, 40, 96};
    // Largest operand magnitude, 127 drives rows into saturation
    localparam int T_MAG  [N_TESTS] = '{15, 20, 127, 30, 10};
    // Random read latency on the last two commands
    localparam bit T_RLAT [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

    logic         clk;
    logic         rst;
    logic         start;
    gemv_cmd_t    cmd;
    tile_rd_req_t rd_req;
    logic         rd_valid;
    buf_tile_t    rd_tile;
    tile_wr_t     wr;
    logic         done;
    logic [2:0]   latency;
    logic         rd_busy;

    int                      seed;
    int                      limit = 0;
    int                      cycle_cnt = 0;
    int                      x_ref [MAX_COLS];
    int                      w_ref [MAX_ROWS][MAX_COLS];
    buf_tile_t               exp_tiles [2];
    int                      exp_tile_cnt;
    logic [BUF_ID_WIDTH-1:0] exp_dest;
    // Bookkeeping per command
    logic                    started;
    int                      wr_seen;
    int                      done_seen;

    gemv_engine #(.MAX_ROWS(MAX_ROWS), .MAX_COLS(MAX_COLS)) u_gemv_engine (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .cmd      (cmd),
        .rd_req   (rd_req),
        .rd_valid (rd_valid),
        .rd_tile  (rd_tile),
        .wr       (wr),
        .done     (done)
    );

    buffer_model u_buffer_model (
        .clk         (clk),
        .rst         (rst),
        .rewind      (start),
        .latency     (latency),
        .rd_req      (rd_req),
        .rd_valid    (rd_valid),
        .rd_tile     (rd_tile),
        .wr          (wr),
        .outstanding (rd_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic int rand_elem(input int mag);
        return $random(seed) % (mag + 1);
    endfunction

    // Shift the row sum down, clamp to int8
    function automatic elem_t requantize(input int sum);
        int s = sum >>> RESULT_SHIFT;
        if (s > 127) begin
            return elem_t'(127);
        end else if (s < -128) begin
            return elem_t'(-128);
        end
        return elem_t'(s);
    endfunction

    function automatic int cycle_budget(input int rows, input int cols);
        return (rows + 1) * (((cols + 31) / 32) * 6 + cols / 6 + 4);
    endfunction

    // =========================================================================
    // Checks
    // =========================================================================
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            started   <= 1'b0;
            wr_seen   <= 0;
            done_seen <= 0;
        end else if (start) begin
            started   <= 1'b1;
            wr_seen   <= 0;
            done_seen <= 0;
        end else begin
            if (wr.valid) begin
                wr_seen <= wr_seen + 1;
            end
            if (done) begin
                done_seen <= done_seen + 1;
            end
        end
    end

    a_quiet : assert property (@(posedge clk) disable iff (rst)
        !started |-> !(done || rd_req.valid || wr.valid))
        else abort_run($sformatf("error at %0t: engine active before the first start", $time));

    a_tile : assert property (@(posedge clk) disable iff (rst)
        wr.valid |-> (wr_seen < exp_tile_cnt && wr.buffer_id == exp_dest &&
                      wr.data == exp_tiles[wr_seen]))
        else abort_run($sformatf("error at %0t: written tile %0d to buffer %0d is wrong",
                                 $time, wr_seen, wr.buffer_id));

    // Done once per command, after every tile is out
    a_done : assert property (@(posedge clk) disable iff (rst)
        done |-> (done_seen == 0 && wr_seen == exp_tile_cnt))
        else abort_run($sformatf("error at %0t: done with %0d of %0d tiles written",
                                 $time, wr_seen, exp_tile_cnt));

    a_one_read : assert property (@(posedge clk) disable iff (rst) rd_req.valid |-> !rd_busy)
        else abort_run($sformatf("error at %0t: read request during an open read", $time));

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > limit) begin
            abort_run($sformatf("timeout after %0d cycles, the engine never finished", cycle_cnt));
        end
    end

    // =========================================================================
    // Stimulus
    // =========================================================================
    task automatic run_command(input int n);
        gemv_cmd_t c;
        buf_tile_t tile;
        int        rows;
        int        cols;
        int        mag;
        int        ntiles;
        int        j;
        int        v;
        int        acc;
        rows   = T_ROWS[n];
        cols   = T_COLS[n];
        mag    = T_MAG[n];
        ntiles = (cols + 31) / 32;
        c.x_buffer_id    = BUF_ID_WIDTH'(2 * n + 1);
        c.w_buffer_id    = BUF_ID_WIDTH'(2 * n + 2);
        c.dest_buffer_id = BUF_ID_WIDTH'(16 + n);
        c.rows           = DIM_WIDTH'(rows);
        c.cols           = DIM_WIDTH'(cols);
        // x tiles, full-range junk past cols
        for (int t = 0; t < ntiles; t++) begin
            for (int p = 0; p < TILE_ELEMS; p++) begin
                j = t * TILE_ELEMS + p;
                v = (j < cols) ? rand_elem(mag) : rand_elem(127);
                if (j < cols) begin
                    x_ref[j] = v;
                end
                tile[p] = elem_t'(v);
            end
            u_buffer_model.mem[c.x_buffer_id][t] = tile;
        end
        // W row-major, each row padded to whole tiles
        for (int r = 0; r < rows; r++) begin
            for (int t = 0; t < ntiles; t++) begin
                for (int p = 0; p < TILE_ELEMS; p++) begin
                    j = t * TILE_ELEMS + p;
                    v = (j < cols) ? rand_elem(mag) : rand_elem(127);
                    // Rows 0 and 1 pinned to +x and -x to hit both limits
                    if (mag == 127 && r < 2 && j < cols) begin
                        v = (r == 0) ? x_ref[j] : -x_ref[j];
                    end
                    if (j < cols) begin
                        w_ref[r][j] = v;
                    end
                    tile[p] = elem_t'(v);
                end
                u_buffer_model.mem[c.w_buffer_id][r * ntiles + t] = tile;
            end
        end
        // Expected result tiles, zero past rows
        exp_tiles[0] = '0;
        exp_tiles[1] = '0;
        for (int r = 0; r < rows; r++) begin
            acc = 0;
            for (int k = 0; k < cols; k++) begin
                acc += w_ref[r][k] * x_ref[k];
            end
            exp_tiles[r / TILE_ELEMS][r % TILE_ELEMS] = requantize(acc);
        end
        exp_tile_cnt = (rows + TILE_ELEMS - 1) / TILE_ELEMS;
        exp_dest     = c.dest_buffer_id;

        @(posedge clk);
        cmd   <= c;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!done) begin
            @(posedge clk);
            latency <= T_RLAT[n] ? 3'(1 + $unsigned($random(seed)) % 4) : 3'd1;
        end
        for (int t = 0; t < exp_tile_cnt; t++) begin
            assert (u_buffer_model.res_mem[exp_dest][t] == exp_tiles[t])
                else abort_run($sformatf("error at %0t: buffer %0d tile %0d holds a wrong result",
                                         $time, exp_dest, t));
        end
    endtask

    initial begin
        seed     = 32'h9ba3;
        rst      = 1'b1;
        start    = 1'b0;
        cmd      = '0;
        latency  = 3'd1;
        for (int n = 0; n < N_TESTS; n++) begin
            limit += cycle_budget(T_ROWS[n], T_COLS[n]);
        end
        // Twice the estimate, plus reset
        limit = 2 * limit + 8;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        for (int n = 0; n < N_TESTS; n++) begin
            run_command(n);
        end
        repeat (3) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: test/buffer_model.sv
`timescale 1ns/1ns

module buffer_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rewind,
    input  logic [2:0]             latency,
    input  gemv_pkg::tile_rd_req_t rd_req,
    output logic                   rd_valid,
    output gemv_pkg::buf_tile_t    rd_tile,
    input  gemv_pkg::tile_wr_t     wr,
    output logic                   outstanding
);
    import gemv_pkg::*;

    // Tiles per buffer id, enough for 40 rows of 3 tiles
    localparam int DEPTH = 128;

    // Operand tiles, loaded by the testbench before each command
    buf_tile_t               mem [32][DEPTH];
    // Result tiles as written by the engine
    buf_tile_t               res_mem [32][4];
    int                      rd_ptr [32];
    int                      wr_ptr [32];
    logic [BUF_ID_WIDTH-1:0] req_id;
    logic [2:0]              wait_cnt;

    // =========================================================================
    // Read response after a chosen latency
    // =========================================================================
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid    <= 1'b0;
            outstanding <= 1'b0;
            wait_cnt    <= '0;
            req_id      <= '0;
            rd_tile     <= '0;
        end else begin
            rd_valid <= 1'b0;
            // Read closes once the engine has seen the tile
            if (rd_valid) begin
                outstanding <= 1'b0;
            end
            if (rd_req.valid) begin
                outstanding <= 1'b1;
                req_id      <= rd_req.buffer_id;
                wait_cnt    <= latency;
            end else if (outstanding && !rd_valid) begin
                if (wait_cnt <= 3'd1) begin
                    rd_valid <= 1'b1;
                    rd_tile  <= mem[req_id][rd_ptr[req_id]];
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
        end
    end

    // Sequential tile pointers, back to tile 0 on every command
    always @(posedge clk) begin
        if (rewind) begin
            for (int i = 0; i < 32; i++) begin
                rd_ptr[i] <= 0;
                wr_ptr[i] <= 0;
            end
        end else begin
            if (rd_valid) begin
                rd_ptr[req_id] <= rd_ptr[req_id] + 1;
            end
            if (wr.valid) begin
                res_mem[wr.buffer_id][wr_ptr[wr.buffer_id]] <= wr.data;
                wr_ptr[wr.buffer_id] <= wr_ptr[wr.buffer_id] + 1;
            end
        end
    end

endmodule

// File: verilog/gemv_engine.sv
`timescale 1ns/1ns

module gemv_engine #(
    parameter int MAX_ROWS = 40,
    parameter int MAX_COLS = 96
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  gemv_pkg::gemv_cmd_t    cmd,
    output gemv_pkg::tile_rd_req_t rd_req,
    input  logic                   rd_valid,
    input  gemv_pkg::buf_tile_t    rd_tile,
    output gemv_pkg::tile_wr_t     wr,
    output logic                   done
);
    import gemv_pkg::*;

    logic                    seg_start;
    logic                    seg_done;
    seg_kind_e               seg_kind;
    logic [BUF_ID_WIDTH-1:0] seg_buffer_id;
    logic                    busy;
    sub_chunk_t              chunk;

    // Lane partial sums and row strobes, one slot per lane
    logic [SUB_ELEMS-1:0][ACC_WIDTH-1:0] partials;
    logic [SUB_ELEMS-1:0]                row_valids;

    gemv_sequencer #(.MAX_ROWS(MAX_ROWS)) u_gemv_sequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .cmd           (cmd),
        .seg_done      (seg_done),
        .pack_done     (done),
        .seg_start     (seg_start),
        .seg_kind      (seg_kind),
        .seg_buffer_id (seg_buffer_id),
        .busy          (busy)
    );

    tile_bridge #(.MAX_COLS(MAX_COLS)) u_tile_bridge (
        .clk           (clk),
        .rst           (rst),
        .cols          (cmd.cols),
        .seg_start     (seg_start),
        .seg_kind      (seg_kind),
        .seg_buffer_id (seg_buffer_id),
        .rd_req        (rd_req),
        .rd_valid      (rd_valid),
        .rd_tile       (rd_tile),
        .chunk         (chunk),
        .seg_done      (seg_done)
    );

    // Lane k owns element k of every sub-tile
    for (genvar k = 0; k < SUB_ELEMS; k++) begin : g_lane
        mac_lane #(.MAX_COLS(MAX_COLS)) u_mac_lane (
            .clk         (clk),
            .rst         (rst),
            .chunk_valid (chunk.valid),
            .chunk_kind  (chunk.kind),
            .chunk_last  (chunk.last),
            .chunk_index (chunk.index),
            .elem        (chunk.data[k]),
            .partial     (partials[k]),
            .row_valid   (row_valids[k])
        );
    end

    result_packer #(.MAX_ROWS(MAX_ROWS)) u_result_packer (
        .clk            (clk),
        .rst            (rst),
        .rows           (cmd.rows),
        .dest_buffer_id (cmd.dest_buffer_id),
        .partials       (partials),
        .row_valids     (row_valids),
        .wr             (wr),
        .done           (done)
    );

    // Bridge and packer read cmd directly, so it must not move mid-command
    a_cmd_stable : assert property (@(posedge clk) disable iff (rst) busy |-> $stable(cmd));

endmodule

// File: verilog/result_packer.sv
`timescale 1ns/1ns

module result_packer #(
    parameter int MAX_ROWS = 40
) (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [gemv_pkg::DIM_WIDTH-1:0]                          rows,
    input  logic [gemv_pkg::BUF_ID_WIDTH-1:0]                       dest_buffer_id,
    input  logic [gemv_pkg::SUB_ELEMS-1:0][gemv_pkg::ACC_WIDTH-1:0] partials,
    input  logic [gemv_pkg::SUB_ELEMS-1:0]                          row_valids,
    output gemv_pkg::tile_wr_t                                      wr,
    output logic                                                    done
);
    import gemv_pkg::*;

    localparam int ROW_W = $clog2(MAX_ROWS + 1);
    localparam int POS_W = $clog2(TILE_ELEMS);

    logic signed [ACC_WIDTH-1:0] sum;
    logic signed [ACC_WIDTH-1:0] scaled;
    elem_t                       y;
    buf_tile_t                   res_q;
    buf_tile_t                   next_tile;
    buf_tile_t                   wr_data_q;
    logic [POS_W-1:0]            pos;
    logic [ROW_W-1:0]            row_cnt;
    logic                        row_in;
    logic                        tile_full;
    logic                        last_row;
    logic                        wr_valid_q;
    logic                        fin_q;

    // =========================================================================
    // Reduce and requantize
    // =========================================================================
    always_comb begin
        sum = '0;
        for (int k = 0; k < SUB_ELEMS; k++) begin
            sum = sum + $signed(partials[k]);
        end
    end

    assign scaled = sum >>> RESULT_SHIFT;
    // Saturate to int8
    assign y = (scaled > 127) ? 8'sd127 : (scaled < -128) ? -8'sd128 : scaled[DATA_WIDTH-1:0];

    always_comb begin
        next_tile      = res_q;
        next_tile[pos] = y;
    end

    assign row_in    = row_valids[0];
    assign tile_full = (pos == POS_W'(TILE_ELEMS - 1));
    assign last_row  = (DIM_WIDTH'(row_cnt) + 1'b1 == rows);

    // =========================================================================
    // Tile packing and flush
    // =========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_q      <= '0;
            pos        <= '0;
            row_cnt    <= '0;
            wr_valid_q <= 1'b0;
            fin_q      <= 1'b0;
            done       <= 1'b0;
        end else begin
            wr_valid_q <= 1'b0;
            fin_q      <= 1'b0;
            done       <= fin_q;
            if (row_in) begin
                // Full tile or last row goes out, next tile starts clean
                if (tile_full || last_row) begin
                    wr_valid_q <= 1'b1;
                    res_q      <= '0;
                    pos        <= '0;
                end else begin
                    res_q <= next_tile;
                    pos   <= pos + 1'b1;
                end
                if (last_row) begin
                    row_cnt <= '0;
                    fin_q   <= 1'b1;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_in) begin
            wr_data_q <= next_tile;
        end
    end

    assign wr = '{valid: wr_valid_q, buffer_id: dest_buffer_id, data: wr_data_q};

    // Lanes see the same chunk stream, so rows finish together
    a_lanes_agree : assert property (@(posedge clk) disable iff (rst)
        |row_valids |-> &row_valids);

endmodule

// File: verilog/gemv_sequencer.sv
`timescale 1ns/1ns

module gemv_sequencer #(
    parameter int MAX_ROWS = 40
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  gemv_pkg::gemv_cmd_t               cmd,
    input  logic                              seg_done,
    input  logic                              pack_done,
    output logic                              seg_start,
    output gemv_pkg::seg_kind_e               seg_kind,
    output logic [gemv_pkg::BUF_ID_WIDTH-1:0] seg_buffer_id,
    output logic                              busy
);
    import gemv_pkg::*;

    localparam int ROW_W = $clog2(MAX_ROWS + 1);

    seq_state_e       state;
    // Weight rows whose segment has been started
    logic [ROW_W-1:0] rows_started;
    // Segment handed to the bridge and not yet finished
    logic             seg_open;

    // Start is ignored unless idle
    assign busy = (state != ST_IDLE);

    // =========================================================================
    // Phase FSM
    // =========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= ST_IDLE;
            seg_start     <= 1'b0;
            seg_kind      <= SEG_X;
            seg_buffer_id <= '0;
            rows_started  <= '0;
        end else begin
            seg_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // x vector goes first
                    if (start) begin
                        seg_start     <= 1'b1;
                        seg_kind      <= SEG_X;
                        seg_buffer_id <= cmd.x_buffer_id;
                        rows_started  <= '0;
                        state         <= ST_LOAD_X;
                    end
                end
                ST_LOAD_X: begin
                    // x stored in lanes, open row 0
                    if (seg_done) begin
                        seg_start     <= 1'b1;
                        seg_kind      <= SEG_W;
                        seg_buffer_id <= cmd.w_buffer_id;
                        rows_started  <= ROW_W'(1);
                        state         <= ST_FEED_W;
                    end
                end
                ST_FEED_W: begin
                    if (seg_done) begin
                        // Last row streamed, results still draining
                        if (DIM_WIDTH'(rows_started) == cmd.rows) begin
                            state <= ST_DRAIN;
                        end else begin
                            seg_start    <= 1'b1;
                            rows_started <= rows_started + 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    // Packer has written its final tile
                    if (pack_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_open <= 1'b0;
        end else if (seg_start) begin
            seg_open <= 1'b1;
        end else if (seg_done) begin
            seg_open <= 1'b0;
        end
    end

    // Bridge handles one segment at a time
    a_no_overlap : assert property (@(posedge clk) disable iff (rst) seg_start |-> !seg_open);

endmodule

// File: verilog/tile_bridge.sv
`timescale 1ns/1ns

module tile_bridge #(
    parameter int MAX_COLS = 96
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [gemv_pkg::DIM_WIDTH-1:0]    cols,
    input  logic                              seg_start,
    input  gemv_pkg::seg_kind_e               seg_kind,
    input  logic [gemv_pkg::BUF_ID_WIDTH-1:0] seg_buffer_id,
    output gemv_pkg::tile_rd_req_t            rd_req,
    input  logic                              rd_valid,
    input  gemv_pkg::buf_tile_t               rd_tile,
    output gemv_pkg::sub_chunk_t              chunk,
    output logic                              seg_done
);
    import gemv_pkg::*;

    localparam int LEFT_W = $clog2(MAX_COLS + 1);
    localparam int POS_W  = $clog2(TILE_ELEMS + 1);

    // Current tile, read position 32 means empty
    buf_tile_t               tile_q;
    logic [POS_W-1:0]        tile_pos;
    // Up to 5 leftover elements from the previous tile
    sub_tile_t               carry_q;
    logic [2:0]              carry_cnt;
    // Elements of the segment not yet emitted
    logic [LEFT_W-1:0]       elems_left;
    logic [3:0]              chunk_idx;
    logic                    seg_active;
    logic                    rd_pending;
    logic                    req_q;
    seg_kind_e               kind_q;
    logic [BUF_ID_WIDTH-1:0] id_q;

    logic                    chunk_valid_q;
    logic                    chunk_last_q;
    seg_kind_e               chunk_kind_q;
    logic [3:0]              chunk_index_q;
    sub_tile_t               chunk_data_q;

    logic [POS_W:0]          avail;
    logic                    can_emit;
    logic                    fetch;
    logic                    last_chunk;
    sub_tile_t               built;

    // =========================================================================
    // Sub-tile assembly
    // =========================================================================
    assign avail      = (POS_W + 1)'(carry_cnt) + (POS_W + 1)'(TILE_ELEMS) - (POS_W + 1)'(tile_pos);
    assign last_chunk = int'(elems_left) <= SUB_ELEMS;
    // Full sub-tile on hand, or everything the segment still needs
    assign can_emit   = seg_active && !rd_pending &&
                        (int'(avail) >= SUB_ELEMS || int'(avail) >= int'(elems_left));
    assign fetch      = seg_active && !rd_pending && !can_emit;

    // Carry first, then tile, zero past the segment end
    always_comb begin
        int src;
        for (int i = 0; i < SUB_ELEMS; i++) begin
            src = int'(tile_pos) + i - int'(carry_cnt);
            if (i < int'(carry_cnt)) begin
                built[i] = carry_q[i];
            end else if (src < TILE_ELEMS) begin
                built[i] = tile_q[src];
            end else begin
                built[i] = '0;
            end
            if (i >= int'(elems_left)) begin
                built[i] = '0;
            end
        end
    end

    // =========================================================================
    // Control
    // =========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_active    <= 1'b0;
            rd_pending    <= 1'b0;
            req_q         <= 1'b0;
            chunk_valid_q <= 1'b0;
            seg_done      <= 1'b0;
            carry_cnt     <= '0;
            tile_pos      <= POS_W'(TILE_ELEMS);
            elems_left    <= '0;
            chunk_idx     <= '0;
            kind_q        <= SEG_X;
            id_q          <= '0;
        end else begin
            req_q         <= 1'b0;
            chunk_valid_q <= 1'b0;
            seg_done      <= 1'b0;
            if (rd_valid) begin
                tile_pos   <= '0;
                rd_pending <= 1'b0;
            end
            if (seg_start) begin
                // Drop any leftovers and fetch the first tile at once
                seg_active <= 1'b1;
                kind_q     <= seg_kind;
                id_q       <= seg_buffer_id;
                elems_left <= LEFT_W'(cols);
                chunk_idx  <= '0;
                carry_cnt  <= '0;
                tile_pos   <= POS_W'(TILE_ELEMS);
                req_q      <= 1'b1;
                rd_pending <= 1'b1;
            end else if (can_emit) begin
                chunk_valid_q <= 1'b1;
                carry_cnt     <= '0;
                tile_pos      <= tile_pos + POS_W'(SUB_ELEMS) - POS_W'(carry_cnt);
                elems_left    <= elems_left - LEFT_W'(SUB_ELEMS);
                chunk_idx     <= chunk_idx + 1'b1;
                if (last_chunk) begin
                    seg_active <= 1'b0;
                    seg_done   <= 1'b1;
                end
            end else if (fetch) begin
                // Tile remainder moves to carry
                carry_cnt  <= 3'(avail);
                tile_pos   <= POS_W'(TILE_ELEMS);
                req_q      <= 1'b1;
                rd_pending <= 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            tile_q <= rd_tile;
        end
        if (can_emit) begin
            chunk_data_q  <= built;
            chunk_kind_q  <= kind_q;
            chunk_last_q  <= last_chunk;
            chunk_index_q <= chunk_idx;
        end else if (fetch) begin
            for (int i = 0; i < SUB_ELEMS; i++) begin
                carry_q[i] <= (int'(tile_pos) + i < TILE_ELEMS) ? tile_q[int'(tile_pos) + i] : '0;
            end
        end
    end

    assign rd_req = '{valid: req_q, buffer_id: id_q};
    assign chunk  = '{valid: chunk_valid_q, kind: chunk_kind_q, last: chunk_last_q,
                      index: chunk_index_q, data: chunk_data_q};

    // One outstanding read at most
    a_one_read : assert property (@(posedge clk) disable iff (rst)
        rd_req.valid |=> (!rd_req.valid throughout rd_valid[->1]));
    // Lanes stay idle from request until the tile arrives
    a_no_emit_in_read : assert property (@(posedge clk) disable iff (rst)
        rd_req.valid |=> (!chunk.valid throughout rd_valid[->1]));

endmodule

// File: verilog/mac_lane.sv
`timescale 1ns/1ns

module mac_lane #(
    parameter int MAX_COLS = 96
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  chunk_valid,
    input  gemv_pkg::seg_kind_e                   chunk_kind,
    input  logic                                  chunk_last,
    input  logic [3:0]                            chunk_index,
    input  gemv_pkg::elem_t                       elem,
    output logic signed [gemv_pkg::ACC_WIDTH-1:0] partial,
    output logic                                  row_valid
);
    import gemv_pkg::*;

    // One x element per sub-tile lands in this lane
    localparam int X_DEPTH = MAX_COLS / SUB_ELEMS;

    elem_t                          x_mem [X_DEPTH];
    logic signed [ACC_WIDTH-1:0]    acc;
    logic signed [ACC_WIDTH-1:0]    acc_next;
    logic signed [2*DATA_WIDTH-1:0] prod;
    logic                           w_beat;
    // Index of the final x sub-tile stored
    logic [3:0]                     x_last_idx;

    assign w_beat   = chunk_valid && (chunk_kind == SEG_W);
    assign prod     = elem * x_mem[chunk_index];
    assign acc_next = acc + ACC_WIDTH'(prod);

    // x store and row result
    always_ff @(posedge clk) begin
        if (chunk_valid && chunk_kind == SEG_X) begin
            x_mem[chunk_index] <= elem;
        end
        if (w_beat && chunk_last) begin
            partial <= acc_next;
        end
    end

    // Accumulator restarts after each row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc        <= '0;
            row_valid  <= 1'b0;
            x_last_idx <= '0;
        end else begin
            row_valid <= w_beat && chunk_last;
            if (w_beat) begin
                acc <= chunk_last ? '0 : acc_next;
            end
            if (chunk_valid && chunk_kind == SEG_X && chunk_last) begin
                x_last_idx <= chunk_index;
            end
        end
    end

    // Weight row never runs past the stored x
    a_index_range : assert property (@(posedge clk) disable iff (rst)
        w_beat |-> chunk_index <= x_last_idx);

endmodule

// File: verilog/gemv_pkg.sv
package gemv_pkg;

    // =========================================================================
    // Widths and limits
    // =========================================================================

    // Signed operand and result element
    localparam int DATA_WIDTH   = 8;
    // Elements per buffer controller tile
    localparam int TILE_ELEMS   = 32;
    // Elements per sub-tile, one per lane
    localparam int SUB_ELEMS    = 6;
    // Lane and row-sum accumulator width
    localparam int ACC_WIDTH    = 24;
    // Row sum scaling before saturation
    localparam int RESULT_SHIFT = 7;
    localparam int BUF_ID_WIDTH = 5;
    localparam int DIM_WIDTH    = 10;

    // =========================================================================
    // Data types
    // =========================================================================

    typedef logic signed [DATA_WIDTH-1:0] elem_t;
    typedef elem_t [TILE_ELEMS-1:0] buf_tile_t;
    typedef elem_t [SUB_ELEMS-1:0] sub_tile_t;

    // Command, held stable by the host while busy
    typedef struct packed {
        logic [BUF_ID_WIDTH-1:0] x_buffer_id;
        logic [BUF_ID_WIDTH-1:0] w_buffer_id;
        logic [BUF_ID_WIDTH-1:0] dest_buffer_id;
        logic [DIM_WIDTH-1:0]    rows;
        logic [DIM_WIDTH-1:0]    cols;
    } gemv_cmd_t;

    // One-cycle read request pulse
    typedef struct packed {
        logic                    valid;
        logic [BUF_ID_WIDTH-1:0] buffer_id;
    } tile_rd_req_t;

    // One-cycle write strobe, always accepted
    typedef struct packed {
        logic                    valid;
        logic [BUF_ID_WIDTH-1:0] buffer_id;
        buf_tile_t               data;
    } tile_wr_t;

    // Segment is the x vector or one weight row
    typedef enum logic {
        SEG_X,
        SEG_W
    } seg_kind_e;

    // Sub-tile on its way to the lanes
    typedef struct packed {
        logic      valid;
        seg_kind_e kind;
        logic      last;
        logic [3:0] index;
        sub_tile_t data;
    } sub_chunk_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD_X,
        ST_FEED_W,
        ST_DRAIN
    } seq_state_e;

endpackage
